// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dram_controller
FILELIST  ?= dram_controller.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dram_bank_dispatch.sv ====
`timescale 1ns/10ps
module dram_bank_dispatch import dram_pkg::*; (
  input  logic                 clk0,
  input  logic                 rst_n,
  input  logic                 init_done,
  input  logic                 q_empty,
  input  app_req_t             q_head,
  output logic                 q_pop,
  input  logic [NUM_BANKS-1:0] bank_idle,
  output logic [NUM_BANKS-1:0] assign_vec,
  output app_req_t             assign_req,
  output logic                 order_push,
  output logic [BANK_BITS-1:0] order_bank,
  input  logic                 order_full
);

  logic target_free;

  // bank is still idle in the strobe cycle, so mask it there
  assign target_free = bank_idle[q_head.bank] && !assign_vec[q_head.bank];
  assign q_pop       = init_done && !q_empty && !order_full && target_free;

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      assign_vec <= '0;
      order_push <= 1'b0;
      order_bank <= '0;
    end else begin
      assign_vec <= q_pop ? (NUM_BANKS'(1) << q_head.bank) : '0;
      order_push <= q_pop;
      if (q_pop) order_bank <= q_head.bank;
    end
  end

  always_ff @(posedge clk0) begin
    if (q_pop) assign_req <= q_head;
  end

endmodule

// ==== dram_bank_machine.sv ====
`timescale 1ns/10ps
module dram_bank_machine import dram_pkg::*; #(
  parameter int T_RCD = 3,
  parameter int T_RAS = 6,
  parameter int T_RP  = 3
) (
  input  logic      clk0,
  input  logic      rst_n,
  input  logic      assign_stb,
  input  app_req_t  req_in,
  input  logic      refresh_pend,
  input  logic      grant,
  output logic      idle,
  output bank_req_t req,
  output logic      closed
);

  localparam int CNT_BITS = $clog2(T_RCD + T_RAS + T_RP + 1);

  logic                row_open;
  logic [ROW_BITS-1:0] open_row;
  logic                pending;
  app_req_t            pend;
  logic [CNT_BITS-1:0] rcd_cnt;
  logic [CNT_BITS-1:0] ras_cnt;
  logic [CNT_BITS-1:0] rp_cnt;

  assign idle   = !pending;
  assign closed = !row_open && (rp_cnt == '0);  // refresh also needs t_rp

  always_comb begin
    req = '{valid: 1'b0, op: OP_NOP, row: open_row, col: '0};
    if (refresh_pend) begin
      if (row_open && ras_cnt == '0) begin  // close the open row before the refresh
        req.valid = 1'b1;
        req.op    = OP_PRECHARGE;
      end
    end else if (pending) begin
      if (!row_open) begin
        if (rp_cnt == '0) begin
          req.valid = 1'b1;
          req.op    = OP_ACTIVATE;
          req.row   = pend.row;
        end
      end else if (open_row != pend.row) begin
        if (ras_cnt == '0) begin  // row miss
          req.valid = 1'b1;
          req.op    = OP_PRECHARGE;
        end
      end else if (rcd_cnt == '0) begin
        req.valid = 1'b1;
        req.op    = pend.rnw ? OP_READ : OP_WRITE;
        req.col   = pend.col;
      end
    end
  end

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      row_open <= 1'b0;
      pending  <= 1'b0;
      rcd_cnt  <= '0;
      ras_cnt  <= '0;
      rp_cnt   <= '0;
    end else begin
      if (rcd_cnt != '0) rcd_cnt <= rcd_cnt - 1'b1;
      if (ras_cnt != '0) ras_cnt <= ras_cnt - 1'b1;
      if (rp_cnt != '0) rp_cnt <= rp_cnt - 1'b1;
      if (assign_stb) pending <= 1'b1;
      if (grant) begin
        case (req.op)
          OP_ACTIVATE: begin
            row_open <= 1'b1;
            rcd_cnt  <= CNT_BITS'(T_RCD - 1);
            ras_cnt  <= CNT_BITS'(T_RAS - 1);
          end
          OP_PRECHARGE: begin
            row_open <= 1'b0;
            rp_cnt   <= CNT_BITS'(T_RP - 1);
          end
          default: pending <= 1'b0;  // column issued so the bank is free again
        endcase
      end
    end
  end

  always_ff @(posedge clk0) begin
    if (assign_stb) pend <= req_in;
    if (grant && req.op == OP_ACTIVATE) open_row <= req.row;
  end

endmodule

// ==== dram_cmd_arbiter.sv ====
`timescale 1ns/10ps
module dram_cmd_arbiter import dram_pkg::*; #(
  parameter int T_RFC  = 8,
  parameter int T_REFI = 400
) (
  input  logic                 clk0,
  input  logic                 rst_n,
  input  logic                 init_done,
  input  dram_cmd_t            init_cmd,
  input  bank_req_t            bank_reqs [NUM_BANKS],
  input  logic [NUM_BANKS-1:0] bank_closed,
  output logic [NUM_BANKS-1:0] grants,
  output logic                 refresh_pend,
  input  logic                 order_push,
  input  logic [BANK_BITS-1:0] order_bank,
  output logic                 order_full,
  input  wr_beat_t             wr_head,
  output logic                 wr_pop,
  output logic                 rd_issue,
  output dram_cmd_t            pin_cmd,
  output logic [DATA_BITS-1:0] dq_out,
  output logic                 dq_oe,
  output logic [BE_BITS-1:0]   dm
);

  localparam int REFI_BITS = $clog2(T_REFI + 1);
  localparam int RFC_BITS  = $clog2(T_RFC + 1);
  localparam int ORD_BITS  = $clog2(NUM_BANKS + 1);

  logic [REFI_BITS-1:0] ref_cnt;
  logic [RFC_BITS-1:0]  rfc_cnt;
  logic [BANK_BITS-1:0] order_ring [NUM_BANKS];
  logic [BANK_BITS-1:0] ord_rd;
  logic [BANK_BITS-1:0] ord_wr;
  logic [ORD_BITS-1:0]  ord_count;
  logic [BANK_BITS-1:0] rr_ptr;
  logic [BANK_BITS-1:0] head_bank;
  logic [BANK_BITS-1:0] idx;
  bank_req_t            head_req;
  dram_cmd_t            sel_cmd;
  logic                 sel_ref;
  logic                 sel_col;
  logic                 found;

  assign head_bank    = order_ring[ord_rd];
  assign head_req     = bank_reqs[head_bank];
  assign refresh_pend = (ref_cnt >= REFI_BITS'(T_REFI));
  assign order_full   = (ord_count == ORD_BITS'(NUM_BANKS));
  assign wr_pop       = sel_col && (sel_cmd.op == OP_WRITE);

  always_comb begin
    sel_cmd = CMD_IDLE;
    grants  = '0;
    sel_ref = 1'b0;
    sel_col = 1'b0;
    found   = 1'b0;
    idx     = rr_ptr;
    if (init_done && rfc_cnt == '0) begin
      if (refresh_pend && &bank_closed) begin
        sel_ref = 1'b1;
        sel_cmd = '{op: OP_REFRESH, bank: '0, addr: '0, cs: 1'b1};
      end else if (ord_count != '0 && head_req.valid &&
                   (head_req.op == OP_READ || head_req.op == OP_WRITE)) begin
        sel_col           = 1'b1;  // columns strictly in request order
        grants[head_bank] = 1'b1;
        sel_cmd = '{op: head_req.op, bank: head_bank, addr: ROW_BITS'(head_req.col), cs: 1'b1};
      end else begin
        for (int i = 0; i < NUM_BANKS; i++) begin
          idx = rr_ptr + BANK_BITS'(i);
          if (!found && bank_reqs[idx].valid &&
              (bank_reqs[idx].op == OP_ACTIVATE || bank_reqs[idx].op == OP_PRECHARGE)) begin
            found       = 1'b1;
            grants[idx] = 1'b1;
            sel_cmd.op   = bank_reqs[idx].op;
            sel_cmd.bank = idx;
            sel_cmd.addr = (bank_reqs[idx].op == OP_ACTIVATE) ? bank_reqs[idx].row : '0;
            sel_cmd.cs   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      ref_cnt   <= '0;
      rfc_cnt   <= '0;
      ord_rd    <= '0;
      ord_wr    <= '0;
      ord_count <= '0;
      rr_ptr    <= '0;
      pin_cmd   <= CMD_IDLE;
      dq_oe     <= 1'b0;
      dm        <= '0;
      rd_issue  <= 1'b0;
    end else begin
      if (!init_done || sel_ref) ref_cnt <= '0;
      else if (!refresh_pend) ref_cnt <= ref_cnt + 1'b1;
      if (sel_ref) rfc_cnt <= RFC_BITS'(T_RFC - 1);
      else if (rfc_cnt != '0) rfc_cnt <= rfc_cnt - 1'b1;
      if (order_push) ord_wr <= ord_wr + 1'b1;
      if (sel_col) ord_rd <= ord_rd + 1'b1;
      case ({order_push, sel_col})
        2'b10:   ord_count <= ord_count + 1'b1;
        2'b01:   ord_count <= ord_count - 1'b1;
        default: ord_count <= ord_count;
      endcase
      if (found) rr_ptr <= sel_cmd.bank + 1'b1;
      pin_cmd  <= init_done ? sel_cmd : init_cmd;  // init sequencer owns the pins until done
      dq_oe    <= wr_pop;
      dm       <= wr_pop ? ~wr_head.be : '0;  // mask is active high
      rd_issue <= sel_col && (sel_cmd.op == OP_READ);
    end
  end

  always_ff @(posedge clk0) begin
    if (order_push) order_ring[ord_wr] <= order_bank;
    if (wr_pop) dq_out <= wr_head.data;  // same cycle as the write on the pins
  end

endmodule

// ==== dram_controller.f ====
dram_pkg.sv
dram_fifo.sv
dram_init_seq.sv
dram_bank_dispatch.sv
dram_bank_machine.sv
dram_cmd_arbiter.sv
dram_rd_capture.sv
dram_controller.sv
tb_dram_model.sv
tb_dram_controller.sv

// ==== dram_controller.sv ====
`timescale 1ns/10ps
module dram_controller import dram_pkg::*; #(
  parameter int T_RCD      = 3,
  parameter int T_RP       = 3,
  parameter int T_RAS      = 6,
  parameter int T_RFC      = 8,
  parameter int T_REFI     = 400,
  parameter int CAS_LAT    = 3,
  parameter int INIT_WAIT  = 20,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                 clk0,
  input  logic                 rst_n,
  output logic                 phy_rdy,
  input  logic [ADDR_BITS-1:0] app_cmd_addr,
  input  logic                 app_cmd_rnw,
  input  logic                 app_cmd_valid,
  input  logic [DATA_BITS-1:0] app_wr_data,
  input  logic [BE_BITS-1:0]   app_wr_be,
  output logic                 app_af_afull,
  output logic [DATA_BITS-1:0] app_rd_data,
  output logic                 app_rd_valid,
  output logic                 dram_cke,
  output logic                 dram_cs_n,
  output logic                 dram_ras_n,
  output logic                 dram_cas_n,
  output logic                 dram_we_n,
  output logic [BANK_BITS-1:0] dram_ba,
  output logic [ROW_BITS-1:0]  dram_a,
  output logic [BE_BITS-1:0]   dram_dm,
  output logic [DATA_BITS-1:0] dram_dq_out,
  output logic                 dram_dq_oe,
  input  logic [DATA_BITS-1:0] dram_dq_in
);

  app_req_t             app_req;
  wr_beat_t             app_beat;
  app_req_t             q_head;
  app_req_t             assign_req;
  wr_beat_t             wr_head;
  dram_cmd_t            init_cmd;
  dram_cmd_t            pin_cmd;
  bank_req_t            bank_reqs [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_idle;
  logic [NUM_BANKS-1:0] bank_closed;
  logic [NUM_BANKS-1:0] assign_vec;
  logic [NUM_BANKS-1:0] grants;
  logic [BANK_BITS-1:0] order_bank;
  logic                 q_empty;
  logic                 q_pop;
  logic                 init_done;
  logic                 order_push;
  logic                 order_full;
  logic                 refresh_pend;
  logic                 wr_pop;
  logic                 rd_issue;

  assign app_req    = {app_cmd_rnw, app_cmd_addr};  // {rnw, bank, row, col}
  assign app_beat   = {app_wr_data, app_wr_be};
  assign dram_cs_n  = ~pin_cmd.cs;
  assign {dram_ras_n, dram_cas_n, dram_we_n} = pin_cmd.op;
  assign dram_ba    = pin_cmd.bank;
  assign dram_a     = pin_cmd.addr;

  dram_fifo #(.T(app_req_t), .DEPTH(FIFO_DEPTH)) cmd_fifo_inst (
    .clk0(clk0), .rst_n(rst_n), .push(app_cmd_valid), .push_data(app_req),
    .pop(q_pop), .pop_data(q_head), .empty(q_empty), .afull(app_af_afull)
  );

  // extra room for writes already handed to the bank machines
  dram_fifo #(.T(wr_beat_t), .DEPTH(FIFO_DEPTH + NUM_BANKS)) wr_fifo_inst (
    .clk0(clk0), .rst_n(rst_n), .push(app_cmd_valid && !app_cmd_rnw), .push_data(app_beat),
    .pop(wr_pop), .pop_data(wr_head), .empty(), .afull()
  );

  dram_init_seq #(.T_RP(T_RP), .T_RFC(T_RFC), .CAS_LAT(CAS_LAT), .INIT_WAIT(INIT_WAIT))
    init_seq_inst (
    .clk0(clk0), .rst_n(rst_n), .init_cmd(init_cmd), .cke(dram_cke),
    .init_done(init_done), .phy_rdy(phy_rdy)
  );

  dram_bank_dispatch dispatch_inst (
    .clk0(clk0), .rst_n(rst_n), .init_done(init_done), .q_empty(q_empty), .q_head(q_head),
    .q_pop(q_pop), .bank_idle(bank_idle), .assign_vec(assign_vec), .assign_req(assign_req),
    .order_push(order_push), .order_bank(order_bank), .order_full(order_full)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    dram_bank_machine #(.T_RCD(T_RCD), .T_RAS(T_RAS), .T_RP(T_RP)) bank_inst (
      .clk0(clk0), .rst_n(rst_n), .assign_stb(assign_vec[b]), .req_in(assign_req),
      .refresh_pend(refresh_pend), .grant(grants[b]), .idle(bank_idle[b]),
      .req(bank_reqs[b]), .closed(bank_closed[b])
    );
  end

  dram_cmd_arbiter #(.T_RFC(T_RFC), .T_REFI(T_REFI)) arbiter_inst (
    .clk0(clk0), .rst_n(rst_n), .init_done(init_done), .init_cmd(init_cmd),
    .bank_reqs(bank_reqs), .bank_closed(bank_closed), .grants(grants),
    .refresh_pend(refresh_pend), .order_push(order_push), .order_bank(order_bank),
    .order_full(order_full), .wr_head(wr_head), .wr_pop(wr_pop), .rd_issue(rd_issue),
    .pin_cmd(pin_cmd), .dq_out(dram_dq_out), .dq_oe(dram_dq_oe), .dm(dram_dm)
  );

  dram_rd_capture #(.CAS_LAT(CAS_LAT)) rd_capture_inst (
    .clk0(clk0), .rst_n(rst_n), .rd_issue(rd_issue), .dq_in(dram_dq_in),
    .rd_data(app_rd_data), .rd_valid(app_rd_valid)
  );

endmodule

// ==== dram_fifo.sv ====
`timescale 1ns/10ps
module dram_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 8
) (
  input  logic clk0,
  input  logic rst_n,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic empty,
  output logic afull
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  T                    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;  // depth need not be a power of two
  endfunction

  assign do_push  = push && (count != CNT_BITS'(DEPTH));
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign afull    = (count >= CNT_BITS'(DEPTH - 1));  // fewer than two free
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk0) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

// ==== dram_init_seq.sv ====
`timescale 1ns/10ps
module dram_init_seq import dram_pkg::*; #(
  parameter int T_RP      = 3,
  parameter int T_RFC     = 8,
  parameter int CAS_LAT   = 3,
  parameter int INIT_WAIT = 20
) (
  input  logic      clk0,
  input  logic      rst_n,
  output dram_cmd_t init_cmd,
  output logic      cke,
  output logic      init_done,
  output logic      phy_rdy
);

  localparam int WAIT_BITS = $clog2(INIT_WAIT + T_RP + T_RFC + 1);

  typedef enum logic [2:0] {S_PWR, S_PRE, S_REF1, S_REF2, S_LMR, S_DONE} init_state_e;

  init_state_e          state;
  logic [WAIT_BITS-1:0] wait_cnt;

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_PWR;
      wait_cnt  <= WAIT_BITS'(INIT_WAIT - 1);
      cke       <= 1'b0;
      init_cmd  <= CMD_IDLE;
      init_done <= 1'b0;
      phy_rdy   <= 1'b0;
    end else begin
      init_cmd <= CMD_IDLE;
      phy_rdy  <= init_done;  // one cycle behind
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else begin
        case (state)
          S_PWR: begin
            cke   <= 1'b1;
            state <= S_PRE;
          end
          S_PRE: begin
            init_cmd <= '{op: OP_PRECHARGE, bank: '0, addr: ROW_BITS'(1 << 10), cs: 1'b1};
            wait_cnt <= WAIT_BITS'(T_RP - 1);
            state    <= S_REF1;
          end
          S_REF1, S_REF2: begin
            init_cmd <= '{op: OP_REFRESH, bank: '0, addr: '0, cs: 1'b1};
            wait_cnt <= WAIT_BITS'(T_RFC - 1);
            state    <= (state == S_REF1) ? S_REF2 : S_LMR;
          end
          S_LMR: begin
            // burst length 1, sequential, cas latency in 6:4
            init_cmd <= '{op: OP_LOAD_MODE, bank: '0, addr: ROW_BITS'(CAS_LAT << 4), cs: 1'b1};
            state    <= S_DONE;
          end
          default: init_done <= 1'b1;
        endcase
      end
    end
  end

endmodule

// ==== dram_pkg.sv ====
package dram_pkg;

  localparam int BANK_BITS = 2;
  localparam int ROW_BITS  = 12;
  localparam int COL_BITS  = 8;
  localparam int DATA_BITS = 32;
  localparam int NUM_BANKS = 1 << BANK_BITS;
  localparam int ADDR_BITS = BANK_BITS + ROW_BITS + COL_BITS;  // app address with the bank on top
  localparam int BE_BITS   = DATA_BITS / 8;

  // values are {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    OP_LOAD_MODE = 3'b000,
    OP_REFRESH   = 3'b001,
    OP_PRECHARGE = 3'b010,
    OP_ACTIVATE  = 3'b011,
    OP_WRITE     = 3'b100,
    OP_READ      = 3'b101,
    OP_NOP       = 3'b111
  } dram_op_e;

  typedef struct packed {
    logic                 rnw;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
    logic [COL_BITS-1:0]  col;
  } app_req_t;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [BE_BITS-1:0]   be;
  } wr_beat_t;

  typedef struct packed {
    logic                valid;
    dram_op_e            op;
    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] col;
  } bank_req_t;

  typedef struct packed {
    dram_op_e             op;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  addr;  // addr[10] selects all banks on precharge
    logic                 cs;
  } dram_cmd_t;

  localparam dram_cmd_t CMD_IDLE = '{op: OP_NOP, bank: '0, addr: '0, cs: 1'b0};

endpackage

// ==== dram_rd_capture.sv ====
`timescale 1ns/10ps
module dram_rd_capture import dram_pkg::*; #(
  parameter int CAS_LAT = 3
) (
  input  logic                 clk0,
  input  logic                 rst_n,
  input  logic                 rd_issue,
  input  logic [DATA_BITS-1:0] dq_in,
  output logic [DATA_BITS-1:0] rd_data,
  output logic                 rd_valid
);

  logic [CAS_LAT-1:0] issue_pipe;  // one flag per cycle since the read left

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      issue_pipe <= '0;
      rd_valid   <= 1'b0;
    end else begin
      issue_pipe <= CAS_LAT'({issue_pipe, rd_issue});
      rd_valid   <= issue_pipe[CAS_LAT-1];
    end
  end

  always_ff @(posedge clk0) begin
    if (issue_pipe[CAS_LAT-1]) rd_data <= dq_in;  // data sits on dq_in this cycle
  end

endmodule

// ==== tb_dram_controller.sv ====
`timescale 1ns/10ps
module tb_dram_controller import dram_pkg::*; ();

  localparam int T_RCD      = 3;
  localparam int T_RP       = 3;
  localparam int T_RAS      = 6;
  localparam int T_RFC      = 8;
  localparam int T_REFI     = 200;
  localparam int CAS_LAT    = 3;
  localparam int INIT_WAIT  = 20;
  localparam int FIFO_DEPTH = 8;
  localparam int MAX_READS  = 1024;
  localparam int RANDOM_OPS = 400;
  localparam int WAIT_LIMIT = 2000;  // cycles

  localparam logic [ADDR_BITS-1:0] ADDR_A = {2'd1, 12'h005, 8'h10};
  localparam logic [ADDR_BITS-1:0] ADDR_B = {2'd2, 12'h7ff, 8'h3c};
  localparam logic [ADDR_BITS-1:0] ADDR_C = {2'd1, 12'h006, 8'h10};  // same bank as a but another row

  logic                 clk0 = 1'b0;
  logic                 rst_n;
  logic                 phy_rdy;
  logic [ADDR_BITS-1:0] app_cmd_addr;
  logic                 app_cmd_rnw;
  logic                 app_cmd_valid;
  logic [DATA_BITS-1:0] app_wr_data;
  logic [BE_BITS-1:0]   app_wr_be;
  logic                 app_af_afull;
  logic [DATA_BITS-1:0] app_rd_data;
  logic                 app_rd_valid;
  logic                 dram_cke;
  logic                 dram_cs_n;
  logic                 dram_ras_n;
  logic                 dram_cas_n;
  logic                 dram_we_n;
  logic [BANK_BITS-1:0] dram_ba;
  logic [ROW_BITS-1:0]  dram_a;
  logic [BE_BITS-1:0]   dram_dm;
  logic [DATA_BITS-1:0] dram_dq_out;
  logic                 dram_dq_oe;
  logic [DATA_BITS-1:0] dram_dq_in;
  logic                 model_fault;

  logic [31:0]          seed = 32'hd284fe8a;
  logic [DATA_BITS-1:0] shadow [logic [ADDR_BITS-1:0]];
  logic [DATA_BITS-1:0] exp_data [MAX_READS];
  string                exp_name [MAX_READS];
  string                test_name;
  int                   reads_sent;
  int                   reads_done = 0;
  int                   cyc = 0;
  int                   rd_cmd_cyc [$];

  always #20 clk0 = ~clk0;

  dram_controller #(
    .T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_RFC(T_RFC), .T_REFI(T_REFI),
    .CAS_LAT(CAS_LAT), .INIT_WAIT(INIT_WAIT), .FIFO_DEPTH(FIFO_DEPTH)
  ) dut0 (
    .clk0(clk0), .rst_n(rst_n), .phy_rdy(phy_rdy), .app_cmd_addr(app_cmd_addr),
    .app_cmd_rnw(app_cmd_rnw), .app_cmd_valid(app_cmd_valid), .app_wr_data(app_wr_data),
    .app_wr_be(app_wr_be), .app_af_afull(app_af_afull), .app_rd_data(app_rd_data),
    .app_rd_valid(app_rd_valid), .dram_cke(dram_cke), .dram_cs_n(dram_cs_n),
    .dram_ras_n(dram_ras_n), .dram_cas_n(dram_cas_n), .dram_we_n(dram_we_n),
    .dram_ba(dram_ba), .dram_a(dram_a), .dram_dm(dram_dm), .dram_dq_out(dram_dq_out),
    .dram_dq_oe(dram_dq_oe), .dram_dq_in(dram_dq_in)
  );

  tb_dram_model #(
    .T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_RFC(T_RFC), .T_REFI(T_REFI),
    .CAS_LAT(CAS_LAT)
  ) model0 (
    .clk0(clk0), .rst_n(rst_n), .cke(dram_cke), .cs_n(dram_cs_n), .ras_n(dram_ras_n),
    .cas_n(dram_cas_n), .we_n(dram_we_n), .ba(dram_ba), .a(dram_a), .dm(dram_dm),
    .dq_out(dram_dq_out), .dq_oe(dram_dq_oe), .dq_in(dram_dq_in), .fault(model_fault)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // writes merge under the byte enables and reads return the shadow word
  function automatic logic [DATA_BITS-1:0] ref_model(input logic rnw,
                                                     input logic [ADDR_BITS-1:0] addr,
                                                     input logic [DATA_BITS-1:0] data,
                                                     input logic [BE_BITS-1:0] be);
    logic [DATA_BITS-1:0] word;
    word = shadow.exists(addr) ? shadow[addr] : '0;
    if (!rnw) begin
      for (int i = 0; i < BE_BITS; i++) begin
        if (be[i]) word[8*i +: 8] = data[8*i +: 8];
      end
      shadow[addr] = word;
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERR %s expected %h actual %h", name, exp_v, act_v);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  // one strobe held back while the command fifo is nearly full
  task automatic send_cmd(input logic rnw, input logic [ADDR_BITS-1:0] addr,
                          input logic [DATA_BITS-1:0] data, input logic [BE_BITS-1:0] be);
    int waited = 0;
    @(posedge clk0);
    #1;
    while (app_af_afull) begin
      app_cmd_valid = 1'b0;
      waited++;
      if (waited > WAIT_LIMIT) abort_run("app_af_afull stayed high too long");
      @(posedge clk0);
      #1;
    end
    app_cmd_addr  = addr;
    app_cmd_rnw   = rnw;
    app_wr_data   = data;
    app_wr_be     = be;
    app_cmd_valid = 1'b1;
    if (rnw) begin
      exp_data[reads_sent] = ref_model(rnw, addr, data, be);
      exp_name[reads_sent] = test_name;
      reads_sent++;
    end else begin
      void'(ref_model(rnw, addr, data, be));
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk0);
    #1;
    app_cmd_valid = 1'b0;
  endtask

  task automatic wait_phy_rdy();
    int waited = 0;
    while (!phy_rdy) begin
      @(posedge clk0);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) abort_run("phy_rdy did not rise after reset");
    end
  endtask

  task automatic wait_reads_drained();
    int waited = 0;
    while (reads_done != reads_sent) begin
      @(posedge clk0);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) abort_run("read data did not come back for all reads");
    end
  endtask

  // read latency from the pins and data in request order
  always @(posedge clk0) begin
    cyc = cyc + 1;
    if (!dram_cs_n && dram_ras_n && !dram_cas_n && dram_we_n) rd_cmd_cyc.push_back(cyc);
    if (app_rd_valid) begin
      if (reads_done >= reads_sent || rd_cmd_cyc.size() == 0) begin
        abort_run("read data returned with no read outstanding");
      end else begin
        check_value({exp_name[reads_done], "_latency"}, CAS_LAT + 1,
                    cyc - rd_cmd_cyc.pop_front());
        check_value(exp_name[reads_done], exp_data[reads_done], app_rd_data);
        reads_done = reads_done + 1;
      end
    end
  end

  always @(posedge model_fault) begin
    $display("Result: FAILED");
    $fatal(1, "memory model reported a timing or protocol violation");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    int          ref_before;
    int          ref_seen;
    rst_n         = 1'b0;
    app_cmd_addr  = '0;
    app_cmd_rnw   = 1'b0;
    app_cmd_valid = 1'b0;
    app_wr_data   = '0;
    app_wr_be     = '0;
    reads_sent    = 0;
    test_name     = "reset";
    repeat (2) @(posedge clk0);
    #1;
    check_value("reset_cke", 0, 32'(dram_cke));
    check_value("reset_pins_nop", 32'hf, 32'({dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n}));
    check_value("reset_phy_rdy", 0, 32'(phy_rdy));
    check_value("reset_rd_valid", 0, 32'(app_rd_valid));
    check_value("reset_dq_oe", 0, 32'(dram_dq_oe));
    check_value("reset_afull", 0, 32'(app_af_afull));
    rst_n = 1'b1;

    test_name = "init_sequence";
    wait_phy_rdy();
    check_value("init_sequence", 4, model0.init_step);  // pre all, ref, ref, load mode seen
    check_value("init_cke", 1, 32'(dram_cke));

    test_name = "write_then_read";
    send_cmd(1'b0, ADDR_A, 32'h1234_5678, 4'hf);
    send_cmd(1'b1, ADDR_A, '0, '0);
    send_cmd(1'b0, ADDR_A, 32'haabb_ccdd, 4'b0101);  // partial merge
    send_cmd(1'b1, ADDR_A, '0, '0);
    send_cmd(1'b1, ADDR_B, '0, '0);  // never written
    send_cmd(1'b0, ADDR_C, 32'h0bad_f00d, 4'hf);
    send_cmd(1'b1, ADDR_A, '0, '0);  // row miss back to a
    send_cmd(1'b1, ADDR_C, '0, '0);
    idle_cycle();
    wait_reads_drained();

    // small row and column range so hits, misses and rereads all occur
    test_name = "random_traffic";
    for (int n = 0; n < RANDOM_OPS; n++) begin
      r = lcg_next();
      d = lcg_next();
      send_cmd(r[24], {r[17:16], 10'd0, r[19:18], 4'd0, r[23:20]}, d, r[28:25]);
    end
    idle_cycle();
    wait_reads_drained();

    // refresh spacing lies between t_refi and the model's interval limit
    test_name  = "refresh_idle";
    ref_before = model0.ref_count;
    repeat (3 * T_REFI) @(posedge clk0);
    #1;
    ref_seen = model0.ref_count - ref_before;
    check_value("refresh_count", 1, 32'(ref_seen >= 2 && ref_seen <= 3));
    check_value("read_cmd_count", 0, 32'(rd_cmd_cyc.size()));
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== tb_dram_model.sv ====
`timescale 1ns/10ps
module tb_dram_model import dram_pkg::*; #(
  parameter int T_RCD   = 3,
  parameter int T_RP    = 3,
  parameter int T_RAS   = 6,
  parameter int T_RFC   = 8,
  parameter int T_REFI  = 400,
  parameter int CAS_LAT = 3
) (
  input  logic                 clk0,
  input  logic                 rst_n,
  input  logic                 cke,
  input  logic                 cs_n,
  input  logic                 ras_n,
  input  logic                 cas_n,
  input  logic                 we_n,
  input  logic [BANK_BITS-1:0] ba,
  input  logic [ROW_BITS-1:0]  a,
  input  logic [BE_BITS-1:0]   dm,
  input  logic [DATA_BITS-1:0] dq_out,
  input  logic                 dq_oe,
  output logic [DATA_BITS-1:0] dq_in,
  output logic                 fault
);

  localparam int REF_LIMIT = T_REFI + T_RAS + T_RP + 4;

  logic [DATA_BITS-1:0] mem [logic [ADDR_BITS-1:0]];  // sparse storage
  logic [ROW_BITS-1:0]  open_row [NUM_BANKS];
  logic [NUM_BANKS-1:0] bank_open;
  int                   act_cyc [NUM_BANKS];
  int                   pre_cyc [NUM_BANKS];
  int                   rd_due [$];  // cycle at which dq_in changes
  logic [DATA_BITS-1:0] rd_val [$];
  int                   cyc;
  int                   ref_cyc;
  int                   last_ref;
  int                   init_step;  // 4 once the mode register is loaded
  int                   ref_count;
  dram_op_e             op;

  task automatic flag(input string msg);
    $display("dram model, cycle %0d: %s", cyc, msg);
    fault = 1'b1;
  endtask

  function automatic dram_op_e init_op(input int step);
    case (step)
      0:       return OP_PRECHARGE;
      3:       return OP_LOAD_MODE;
      default: return OP_REFRESH;
    endcase
  endfunction

  task automatic column(input dram_op_e cmd);
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] word;
    addr = {ba, open_row[ba], a[COL_BITS-1:0]};
    word = mem.exists(addr) ? mem[addr] : '0;  // unwritten reads as zero
    if (!bank_open[ba]) flag("column command to a closed bank");
    if (cyc - act_cyc[ba] < T_RCD) flag("activate to column command shorter than t_rcd");
    if (cmd == OP_READ) begin
      rd_due.push_back(cyc + CAS_LAT - 1);  // lands on dq_in cas_lat after the pins
      rd_val.push_back(word);
    end else begin
      if (!dq_oe) flag("write command without write data on the bus");
      for (int i = 0; i < BE_BITS; i++) begin
        if (!dm[i]) word[8*i +: 8] = dq_out[8*i +: 8];
      end
      mem[addr] = word;
    end
  endtask

  always @(posedge clk0) begin
    if (!rst_n) begin
      cyc       = 0;
      ref_cyc   = -1000;
      last_ref  = 0;
      init_step = 0;
      ref_count = 0;
      bank_open = '0;
      fault     = 1'b0;
      dq_in     <= '0;
      rd_due.delete();
      rd_val.delete();
      for (int b = 0; b < NUM_BANKS; b++) begin
        act_cyc[b]  = -1000;
        pre_cyc[b]  = -1000;
        open_row[b] = '0;
      end
    end else begin
      cyc = cyc + 1;
      if (rd_due.size() != 0 && rd_due[0] == cyc) begin
        void'(rd_due.pop_front());
        dq_in <= rd_val.pop_front();
      end
      if (init_step == 4 && cyc - last_ref > REF_LIMIT) flag("refresh interval exceeded");
      if (!cs_n) begin
        op = dram_op_e'({ras_n, cas_n, we_n});
        if (!cke) flag("command while cke is low");
        if (cyc - ref_cyc < T_RFC) flag("command sooner than t_rfc after a refresh");
        if (init_step < 4 && op != init_op(init_step)) flag("initialization commands out of order");
        if (init_step == 0 && !a[10]) flag("first precharge does not close all banks");
        case (op)
          OP_ACTIVATE: begin
            if (bank_open[ba]) flag("activate to a bank that is already open");
            if (cyc - pre_cyc[ba] < T_RP) flag("precharge to activate shorter than t_rp");
            bank_open[ba] = 1'b1;
            open_row[ba]  = a;
            act_cyc[ba]   = cyc;
          end
          OP_READ, OP_WRITE: column(op);
          OP_PRECHARGE: begin
            for (int b = 0; b < NUM_BANKS; b++) begin
              if (a[10] || BANK_BITS'(b) == ba) begin
                if (bank_open[b] && cyc - act_cyc[b] < T_RAS) begin
                  flag("activate to precharge shorter than t_ras");
                end
                bank_open[b] = 1'b0;
                pre_cyc[b]   = cyc;
              end
            end
          end
          OP_REFRESH: begin
            if (bank_open != '0) flag("refresh while a bank is open");
            for (int b = 0; b < NUM_BANKS; b++) begin
              if (cyc - pre_cyc[b] < T_RP) flag("precharge to refresh shorter than t_rp");
            end
            ref_cyc   = cyc;
            last_ref  = cyc;
            ref_count = ref_count + 1;
          end
          OP_LOAD_MODE: begin
            if (init_step != 3) flag("mode register load outside initialization");
            if (a[6:4] != 3'(CAS_LAT)) flag("mode register cas latency does not match");
            last_ref = cyc;  // refresh interval starts here
          end
          default: ;
        endcase
        if (init_step < 4) init_step = init_step + 1;
      end
    end
  end

endmodule
